/* list.f */
hdl/screen_geom_pkg.sv
hdl/prize_pkg.sv
hdl/grid_addresser.sv
hdl/prize_layer.sv
hdl/prize_mixer.sv
hdl/prize_field.sv
bench/prize_field_tb.sv

/* Bender.yml */
package:
  name: prize_field

sources:
  - hdl/screen_geom_pkg.sv
  - hdl/prize_pkg.sv
  - hdl/grid_addresser.sv
  - hdl/prize_layer.sv
  - hdl/prize_mixer.sv
  - hdl/prize_field.sv
  - target: test
    files:
      - bench/prize_field_tb.sv

/* bench/prize_field_tb.sv */
`timescale 1ns/1ps

module prize_field_tb;
	import screen_geom_pkg::*;
	import prize_pkg::*;

	localparam int NL = 2;
	localparam int CLK_PERIOD = 10;
	localparam int SCAN_LEN = 300;
	localparam int NUM_HITS = 40;
	// Reset, six scans, the event bursts and the drain cycles of each test.
	localparam int RUN_CYCLES = 6 * SCAN_LEN + 6 * NUM_HITS + 40;

	logic       clk = 1'b0;
	logic       resetN;
	coord_t     pixel_x, pixel_y, player_x, player_y;
	logic       prize_hit, block_hit, next_level, player_alive;
	edge_t      hit_edge;
	level_t     level;
	logic [9:0] random_bits;
	logic       draw;
	cell_t      prize_kind;
	coord_t     tile_left, tile_top;
	logic [1:0] color_variant;

	// Reference model state.
	cell_t      mmap [NL][GRID_ROWS][GRID_COLS];
	cell_t      s2_kind [NL];
	tile_addr_t s1, s2_where, pend_where, pt;
	logic       pend_take, pend_bump, pend_reload;
	level_t     pend_level;
	logic       exp_draw;
	cell_t      exp_kind;
	coord_t     exp_left, exp_top;
	logic [1:0] exp_color;
	int         quiet;

	int seed = 40692;
	int errors = 0, checks = 0, tests = 0, failed_tests = 0, test_start = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	prize_field #(.NUM_LAYERS(NL)) prize_field_inst (.*);

	function automatic int rnd(input int n);
		int unsigned r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	// Tile of a pixel, 64 pixels per tile, 10 by 7 tiles on the grid.
	function automatic tile_addr_t tile_of(input coord_t x, input coord_t y);
		tile_addr_t t;
		t.col = col_t'(x >> TILE_SHIFT);
		t.row = row_t'(y >> TILE_SHIFT);
		t.on_grid = ((x >> TILE_SHIFT) < GRID_COLS) && ((y >> TILE_SHIFT) < GRID_ROWS);
		return t;
	endfunction

	// Cycle model of the three pipeline stages and the map updates.
	always @(posedge clk) begin
		if (!resetN) begin
			for (int l = 0; l < NL; l++) begin
				mmap[l] = LEVEL_MAPS[l][0];
				s2_kind[l] = CELL_FREE;
			end
			s1 = '0;
			s2_where = '0;
			{pend_take, pend_bump, pend_reload, pend_level} = '0;
			exp_draw = 1'b0;
			exp_kind = CELL_FREE;
			quiet = 0;
		end else begin
			// Lowest non-free layer wins.
			exp_draw = 1'b0;
			exp_kind = CELL_FREE;
			for (int l = 0; l < NL; l++) begin
				if (!exp_draw && s2_kind[l] != CELL_FREE) begin
					exp_draw = 1'b1;
					exp_kind = s2_kind[l];
				end
			end
			exp_left = coord_t'(s2_where.col) * 64;
			exp_top = coord_t'(s2_where.row) * 64;
			exp_color = {random_bits[s2_where.row], random_bits[s2_where.col]};
			for (int l = 0; l < NL; l++) begin
				s2_kind[l] = s1.on_grid ? mmap[l][s1.row][s1.col] : CELL_FREE;
			end
			s2_where = s1;
			s1 = tile_of(pixel_x, pixel_y);
			// Updates sampled at the previous edge land now, reload first.
			if (pend_reload) begin
				for (int l = 0; l < NL; l++) begin
					mmap[l] = LEVEL_MAPS[l][pend_level];
				end
			end else if (pend_take) begin
				mmap[0][pend_where.row][pend_where.col] = CELL_FREE;
			end else if (pend_bump) begin
				mmap[NL-1][pend_where.row][pend_where.col] = CELL_COIN;
			end
			pt = tile_of(player_x, player_y);
			pend_where = pt;
			pend_take = prize_hit && pt.on_grid;
			pend_bump = block_hit && (hit_edge == EDGE_BOTTOM) && !prize_hit && pt.on_grid;
			pend_reload = next_level || !player_alive;
			pend_level = level;
			if (prize_hit || block_hit || pend_reload) begin
				quiet = 0;
			end else if (quiet < 3) begin
				quiet++;
			end
		end
	end

	task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
		checks++;
		if (actv !== expv) begin
			errors++;
			$display("Mismatch at %0d ns: %s expected %0d, got %0d", $time, name, expv, actv);
		end
	endtask

	// Outputs are compared half a cycle after the edge that registered them.
	always @(negedge clk) begin
		if (resetN && quiet >= 3) begin
			check("draw", exp_draw, draw);
			check("prize_kind", exp_kind, prize_kind);
			if (exp_draw) begin
				check("tile_left", exp_left, tile_left);
				check("tile_top", exp_top, tile_top);
				check("color_variant", exp_color, color_variant);
			end
		end
	end

	task automatic scan(input int n, input int xmax, input int ymax);
		repeat (n) begin
			@(posedge clk);
			pixel_x <= coord_t'(rnd(xmax));
			pixel_y <= coord_t'(rnd(ymax));
			random_bits <= 10'(rnd(1024));
		end
	endtask

	// One event cycle at a random player position, then one idle cycle.
	task automatic pulse(input logic take, input logic blk, input edge_t e,
			input logic nxt, input logic dead, input level_t lvl);
		@(posedge clk);
		player_x <= coord_t'(rnd(704));
		player_y <= coord_t'(rnd(480));
		prize_hit <= take;
		block_hit <= blk;
		hit_edge <= e;
		next_level <= nxt;
		player_alive <= !dead;
		level <= lvl;
		@(posedge clk);
		{prize_hit, block_hit, next_level} <= 3'b000;
		player_alive <= 1'b1;
	endtask

	task automatic end_test(input string name);
		repeat (4) @(posedge clk);
		tests++;
		if (errors == test_start) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: %0d errors", tests, name, errors - test_start);
		end
		test_start = errors;
	endtask

	initial begin
		#((RUN_CYCLES + 200) * CLK_PERIOD);
		$display("Timeout, the tests did not finish in time");
		$display("Checks failed");
		$finish;
	end

	initial begin
		resetN = 1'b0;
		{pixel_x, pixel_y, player_x, player_y} = '0;
		{prize_hit, block_hit, next_level} = 3'b000;
		player_alive = 1'b1;
		hit_edge = '0;
		level = '0;
		random_bits = '0;
		repeat (2) @(posedge clk);
		resetN <= 1'b1;

		scan(SCAN_LEN, 2048, 2048);
		end_test("level 0 maps after reset");

		repeat (NUM_HITS) pulse(1'b1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
		scan(SCAN_LEN, 704, 480);
		end_test("prize hits clear layer 0");

		// Half the hits come from below, some collide with a take.
		repeat (NUM_HITS) pulse(rnd(8) == 0, 1'b1,
			rnd(2) ? EDGE_BOTTOM : edge_t'(rnd(16)), 1'b0, 1'b0, 1'b0);
		scan(SCAN_LEN, 704, 480);
		end_test("block hits place coins");

		pulse(1'b1, 1'b0, '0, 1'b1, 1'b0, 1'b1);
		scan(SCAN_LEN, 704, 480);
		repeat (NUM_HITS) pulse(rnd(2), 1'b1, EDGE_BOTTOM, 1'b0, 1'b0, 1'b1);
		pulse(1'b0, 1'b1, EDGE_BOTTOM, 1'b0, 1'b1, 1'b1);
		scan(SCAN_LEN, 704, 480);
		end_test("level change and death reload");

		scan(SCAN_LEN, 640, 448);
		end_test("colour variant and tile corner");

		$display("Tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* hdl/prize_field.sv */
`timescale 1ns/1ps

module prize_field #(
	parameter int NUM_LAYERS = 2
) (
	input  logic                    clk,
	input  logic                    resetN,
	input  screen_geom_pkg::coord_t pixel_x,
	input  screen_geom_pkg::coord_t pixel_y,
	input  screen_geom_pkg::coord_t player_x,
	input  screen_geom_pkg::coord_t player_y,
	input  logic                    prize_hit,
	input  logic                    block_hit,
	input  prize_pkg::edge_t        hit_edge,
	input  prize_pkg::level_t       level,
	input  logic                    next_level,
	input  logic                    player_alive,
	input  logic [9:0]              random_bits,
	output logic                    draw,
	output prize_pkg::cell_t        prize_kind,
	output screen_geom_pkg::coord_t tile_left,
	output screen_geom_pkg::coord_t tile_top,
	output logic [1:0]              color_variant
);
	import screen_geom_pkg::*;
	import prize_pkg::*;

	tile_addr_t  pixel_tile;
	map_event_t  map_event;
	layer_read_t reads [NUM_LAYERS];
	logic        reload;

	// Level change or death restores the compiled-in map.
	assign reload = next_level || !player_alive;

	if (NUM_LAYERS < 1 || NUM_LAYERS > MAX_LAYERS) begin : g_bad_layers
		$error("NUM_LAYERS out of range.");
	end

	grid_addresser #(
		.NUM_LAYERS(NUM_LAYERS)
	) addresser_inst (
		.clk        (clk),
		.resetN     (resetN),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y),
		.player_x   (player_x),
		.player_y   (player_y),
		.prize_hit  (prize_hit),
		.block_hit  (block_hit),
		.hit_edge   (hit_edge),
		.pixel_tile (pixel_tile),
		.map_event  (map_event)
	);

	for (genvar gi = 0; gi < NUM_LAYERS; gi++) begin : g_layer
		prize_layer #(
			.LAYER_ID(gi)
		) layer_inst (
			.clk        (clk),
			.resetN     (resetN),
			.pixel_tile (pixel_tile),
			.map_event  (map_event),
			.reload     (reload),
			.level      (level),
			.read       (reads[gi])
		);
	end

	prize_mixer #(
		.NUM_LAYERS(NUM_LAYERS)
	) mixer_inst (
		.clk           (clk),
		.resetN        (resetN),
		.reads         (reads),
		.random_bits   (random_bits),
		.draw          (draw),
		.prize_kind    (prize_kind),
		.tile_left     (tile_left),
		.tile_top      (tile_top),
		.color_variant (color_variant)
	);

endmodule

/* hdl/prize_mixer.sv */
`timescale 1ns/1ps

module prize_mixer #(
	parameter int NUM_LAYERS = 2
) (
	input  logic                    clk,
	input  logic                    resetN,
	input  prize_pkg::layer_read_t  reads [NUM_LAYERS],
	input  logic [9:0]              random_bits,
	output logic                    draw,
	output prize_pkg::cell_t        prize_kind,
	output screen_geom_pkg::coord_t tile_left,
	output screen_geom_pkg::coord_t tile_top,
	output logic [1:0]              color_variant
);
	import screen_geom_pkg::*;
	import prize_pkg::*;

	layer_read_t winner;
	logic        any_hit;
	logic        col_bit;

	// Scan from the top index down so the lowest non-free layer ends up last.
	always_comb begin
		winner  = reads[0];
		any_hit = 1'b0;
		for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
			if (reads[i].kind != CELL_FREE) begin
				winner  = reads[i];
				any_hit = 1'b1;
			end
		end
	end

	// Columns past the grid have no matching random bit.
	assign col_bit = winner.where.on_grid ? random_bits[winner.where.col] : 1'b0;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			draw          <= 1'b0;
			prize_kind    <= CELL_FREE;
			tile_left     <= '0;
			tile_top      <= '0;
			color_variant <= '0;
		end else begin
			draw          <= any_hit;
			prize_kind    <= winner.kind;
			tile_left     <= coord_t'(winner.where.col) << TILE_SHIFT;
			tile_top      <= coord_t'(winner.where.row) << TILE_SHIFT;
			color_variant <= {random_bits[winner.where.row], col_bit};
		end
	end

	no_kind_without_draw: assert property (@(posedge clk) disable iff (!resetN)
		!draw |-> (prize_kind == CELL_FREE));

endmodule

/* hdl/prize_layer.sv */
`timescale 1ns/1ps

module prize_layer #(
	parameter int LAYER_ID = 0
) (
	input  logic                        clk,
	input  logic                        resetN,
	input  screen_geom_pkg::tile_addr_t pixel_tile,
	input  prize_pkg::map_event_t       map_event,
	input  logic                        reload,
	input  prize_pkg::level_t           level,
	output prize_pkg::layer_read_t      read
);
	import screen_geom_pkg::*;
	import prize_pkg::*;

	cell_t  cells [GRID_ROWS][GRID_COLS];
	logic   reload_q;
	level_t level_q;
	logic   event_here;

	// Reload lines up with the event path, one cycle after sampling.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			reload_q <= 1'b0;
			level_q  <= '0;
		end else begin
			reload_q <= reload;
			level_q  <= level;
		end
	end

	assign event_here = (map_event.layer == 1'(LAYER_ID));

	// Map storage.
	// A reload overrides any event in the same cycle.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cells <= LEVEL_MAPS[LAYER_ID][0];
		end else if (reload_q) begin
			cells <= LEVEL_MAPS[LAYER_ID][level_q];
		end else if (event_here) begin
			if (map_event.take) begin
				cells[map_event.where.row][map_event.where.col] <= CELL_FREE;
			end else if (map_event.bump) begin
				cells[map_event.where.row][map_event.where.col] <= CELL_COIN;
			end
		end
	end

	// Per-pixel lookup, one stage after the addresser.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			read.kind  <= CELL_FREE;
			read.where <= '0;
		end else begin
			read.where <= pixel_tile;
			if (pixel_tile.on_grid) begin
				read.kind <= cells[pixel_tile.row][pixel_tile.col];
			end else begin
				read.kind <= CELL_FREE;
			end
		end
	end

	// Off-grid player positions must never produce an event.
	event_in_range: assert property (@(posedge clk) disable iff (!resetN)
		(map_event.take || map_event.bump) |->
			map_event.where.on_grid &&
			(map_event.where.row < GRID_ROWS) &&
			(map_event.where.col < GRID_COLS));

endmodule

/* hdl/grid_addresser.sv */
`timescale 1ns/1ps

module grid_addresser #(
	parameter int NUM_LAYERS = 2
) (
	input  logic                        clk,
	input  logic                        resetN,
	input  screen_geom_pkg::coord_t     pixel_x,
	input  screen_geom_pkg::coord_t     pixel_y,
	input  screen_geom_pkg::coord_t     player_x,
	input  screen_geom_pkg::coord_t     player_y,
	input  logic                        prize_hit,
	input  logic                        block_hit,
	input  prize_pkg::edge_t            hit_edge,
	output screen_geom_pkg::tile_addr_t pixel_tile,
	output prize_pkg::map_event_t       map_event
);
	import screen_geom_pkg::*;
	import prize_pkg::*;

	// Bumps always land in the last layer.
	localparam logic BUMP_LAYER = 1'(NUM_LAYERS - 1);
	localparam int IDX_W = $bits(coord_t) - TILE_SHIFT;

	tile_addr_t pixel_addr;
	tile_addr_t player_addr;
	logic       bottom_bump;

	function automatic tile_addr_t to_tile(input coord_t x, input coord_t y);
		logic [IDX_W-1:0] cx;
		logic [IDX_W-1:0] cy;
		tile_addr_t       t;
		cx = x[$bits(coord_t)-1:TILE_SHIFT];
		cy = y[$bits(coord_t)-1:TILE_SHIFT];
		t.col = col_t'(cx);
		t.row = row_t'(cy);
		// Compare before truncation so wide coordinates stay off grid.
		t.on_grid = (cx < GRID_COLS) && (cy < GRID_ROWS);
		return t;
	endfunction

	assign pixel_addr  = to_tile(pixel_x, pixel_y);
	assign player_addr = to_tile(player_x, player_y);
	assign bottom_bump = block_hit && (hit_edge == EDGE_BOTTOM);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixel_tile <= '0;
			map_event  <= '0;
		end else begin
			pixel_tile      <= pixel_addr;
			map_event.where <= player_addr;
			map_event.take  <= prize_hit && player_addr.on_grid;
			// A take in the same cycle wins over the bump.
			map_event.bump  <= bottom_bump && !prize_hit && player_addr.on_grid;
			map_event.layer <= prize_hit ? 1'b0 : BUMP_LAYER;
		end
	end

	// Bottom bump dropped in favour of a take.
	bump_dropped: cover property (@(posedge clk) disable iff (!resetN)
		prize_hit && bottom_bump)
		$info("Bump discarded, take event wins.");

endmodule

/* hdl/prize_pkg.sv */
package prize_pkg;

	// Content of one map cell.
	typedef enum logic [2:0] {
		CELL_FREE = 3'd0,
		CELL_COIN = 3'd1,
		CELL_GEM  = 3'd2
	} cell_t;

	// Edge code from the collision logic, one bit per block edge.
	typedef logic [3:0] edge_t;
	localparam edge_t EDGE_BOTTOM = 4'b0100;

	localparam int NUM_LEVELS = 2;
	localparam int MAX_LAYERS = 2;

	typedef logic level_t;

	// Single-cycle map update, aimed at one layer.
	typedef struct packed {
		logic take;
		logic bump;
		logic layer;
		screen_geom_pkg::tile_addr_t where;
	} map_event_t;

	// Cell seen by one layer for the current pixel.
	typedef struct packed {
		cell_t kind;
		screen_geom_pkg::tile_addr_t where;
	} layer_read_t;

	// Compiled-in maps, indexed by layer, level, row and column.
	// Layer 0 holds collectables, layer 1 holds coins that bumps reveal.
	localparam cell_t LEVEL_MAPS [MAX_LAYERS][NUM_LEVELS]
		[screen_geom_pkg::GRID_ROWS][screen_geom_pkg::GRID_COLS] = '{
		'{
			'{
				'{default: CELL_FREE},
				'{1: CELL_COIN, 2: CELL_COIN, 3: CELL_COIN, default: CELL_FREE},
				'{7: CELL_GEM, default: CELL_FREE},
				'{default: CELL_FREE},
				'{0: CELL_COIN, 5: CELL_GEM, 9: CELL_COIN, default: CELL_FREE},
				'{default: CELL_FREE},
				'{2: CELL_COIN, 3: CELL_COIN, default: CELL_FREE}
			},
			'{
				'{9: CELL_GEM, default: CELL_FREE},
				'{default: CELL_COIN},
				'{default: CELL_FREE},
				'{4: CELL_COIN, 5: CELL_COIN, default: CELL_FREE},
				'{default: CELL_FREE},
				'{0: CELL_GEM, 8: CELL_COIN, default: CELL_FREE},
				'{default: CELL_FREE}
			}
		},
		'{
			'{
				'{default: CELL_FREE},
				'{default: CELL_FREE},
				'{default: CELL_FREE},
				'{2: CELL_COIN, default: CELL_FREE},
				'{5: CELL_COIN, default: CELL_FREE},
				'{default: CELL_FREE},
				'{default: CELL_FREE}
			},
			'{
				'{default: CELL_FREE},
				'{default: CELL_FREE},
				'{6: CELL_COIN, default: CELL_FREE},
				'{default: CELL_FREE},
				'{default: CELL_FREE},
				'{default: CELL_FREE},
				'{default: CELL_FREE}
			}
		}
	};

endpackage

/* hdl/screen_geom_pkg.sv */
package screen_geom_pkg;

	// Pixel position on the screen, wide enough for the full VGA raster.
	typedef logic [10:0] coord_t;

	// Tiles are 64 by 64 pixels.
	localparam int TILE_SHIFT = 6;

	// 10 by 7 tiles cover 640 by 448 pixels.
	localparam int GRID_COLS = 10;
	localparam int GRID_ROWS = 7;

	typedef logic [3:0] col_t;
	typedef logic [2:0] row_t;

	// Tile address as seen by the prize layers.
	// Col and row are only meaningful while on_grid is set.
	typedef struct packed {
		col_t col;
		row_t row;
		logic on_grid;
	} tile_addr_t;

endpackage
